/* logic/cache_cfg.svh */
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// cpu address and data share one width
`define CACHE_ADDR_W 32

// tag bits kept per line
`define CACHE_TAG_W 24

// log2 of bytes per line
`define CACHE_LINE_BYTES_W 4

// whatever is left between tag and line bytes
`define CACHE_INDEX_W (`CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_LINE_BYTES_W)

`define CACHE_NUM_LINES (1 << `CACHE_INDEX_W)

// word within line
`define CACHE_OFFSET_W (`CACHE_LINE_BYTES_W - 2)

`define CACHE_WORDS (1 << `CACHE_OFFSET_W)

`endif

/* logic/cache_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package cache_pkg;

    localparam int ADDR_W     = `CACHE_ADDR_W;
    localparam int DATA_W     = `CACHE_ADDR_W;
    localparam int TAG_W      = `CACHE_TAG_W;
    localparam int INDEX_W    = `CACHE_INDEX_W;
    localparam int OFFSET_W   = `CACHE_OFFSET_W;
    localparam int BYTE_OFF_W = `CACHE_LINE_BYTES_W - `CACHE_OFFSET_W;
    localparam int NUM_LINES  = `CACHE_NUM_LINES;
    localparam int WORDS      = `CACHE_WORDS;
    localparam int STRB_W     = DATA_W / 8;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } cpu_size_t;

    // wdata arrives already placed in its byte lanes
    typedef struct packed {
        logic              req;
        logic              wr;
        cpu_size_t         size;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [INDEX_W-1:0]    index;
        logic [OFFSET_W-1:0]   offset;
        logic [BYTE_OFF_W-1:0] byte_off;
    } addr_fields_t;

    // one write command seen by every line
    typedef struct packed {
        logic                en;
        logic [INDEX_W-1:0]  index;
        logic [TAG_W-1:0]    tag;
        logic [OFFSET_W-1:0] offset;
        logic [DATA_W-1:0]   data;
        logic [STRB_W-1:0]   strb;
        logic                dirty;
        logic                valid;
    } line_wr_t;

    typedef struct packed {
        logic [WORDS-1:0][DATA_W-1:0] words;
        logic [TAG_W-1:0]             tag;
        logic                         valid;
        logic                         dirty;
    } line_rd_t;

endpackage

`default_nettype wire

/* logic/mem_bus_pkg.sv */
`default_nettype none

`include "cache_cfg.svh"

package mem_bus_pkg;

    localparam int BUS_W = `CACHE_ADDR_W;
    localparam int LEN_W = 4;

    // one burst moves a whole line
    localparam logic [LEN_W-1:0] LINE_LEN = LEN_W'(`CACHE_WORDS - 1);

    localparam logic [1:0] BURST_WRAP     = 2'd2;
    localparam logic [2:0] BEAT_SIZE_WORD = 3'd2;

    // address channel, used for both AR and AW
    typedef struct packed {
        logic [BUS_W-1:0] addr;
        logic [LEN_W-1:0] len;
        logic [2:0]       size;
        logic [1:0]       burst;
        logic             valid;
    } ar_req_t;

    typedef struct packed {
        logic [BUS_W-1:0]   data;
        logic [BUS_W/8-1:0] strb;
        logic               last;
        logic               valid;
    } w_req_t;

    typedef struct packed {
        logic [BUS_W-1:0] data;
        logic             last;
        logic             valid;
    } r_rsp_t;

endpackage

`default_nettype wire

/* logic/cache_line.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_line (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                index_match,
    input  wire cache_pkg::line_wr_t wr,
    output cache_pkg::line_rd_t      line
);
    import cache_pkg::*;

    logic [WORDS-1:0][DATA_W-1:0] words;
    logic [TAG_W-1:0]             tag;
    logic                         valid;
    logic                         dirty;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            dirty <= 1'b0;
        end else if (index_match) begin
            valid <= wr.valid;
            dirty <= wr.dirty;
        end
    end

    // byte merge into the addressed word
    always_ff @(posedge clk) begin
        if (index_match) begin
            tag <= wr.tag;
            for (int b = 0; b < STRB_W; b++) begin
                if (wr.strb[b]) begin
                    words[wr.offset][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

    assign line = '{
        words: words,
        tag:   tag,
        valid: valid,
        dirty: dirty
    };

    // a write carrying no bytes only ever comes from write-back, to drop the line
    a_empty_write_invalidates: assert property (
        @(posedge clk) disable iff (rst)
        index_match && (wr.strb == '0) |-> !wr.valid && !wr.dirty
    );

endmodule

`default_nettype wire

/* logic/line_select.sv */
`timescale 1ns/1ps
`default_nettype none

module line_select (
    input  wire cache_pkg::line_rd_t           lines [cache_pkg::NUM_LINES],
    input  wire logic [cache_pkg::INDEX_W-1:0]  index,
    input  wire logic [cache_pkg::TAG_W-1:0]    tag,
    input  wire logic [cache_pkg::OFFSET_W-1:0] word,
    output logic                               hit,
    output logic                               line_valid,
    output logic                               line_dirty,
    output logic [cache_pkg::TAG_W-1:0]        victim_tag,
    output logic [cache_pkg::DATA_W-1:0]       rd_word
);
    import cache_pkg::*;

    line_rd_t sel;
    logic     tag_eq;

    assign sel = lines[index];

    assign tag_eq     = (sel.tag == tag);
    assign hit        = tag_eq && sel.valid;
    assign line_valid = sel.valid;
    assign line_dirty = sel.dirty;

    // stored tag doubles as the write-back address
    assign victim_tag = sel.tag;
    assign rd_word    = sel.words[word];

endmodule

`default_nettype wire

/* logic/cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire cache_pkg::cpu_req_t            cpu,
    output logic [cache_pkg::DATA_W-1:0]        rdata,
    output logic                                addr_ok,
    output logic                                data_ok,
    output logic [cache_pkg::INDEX_W-1:0]       index,
    output logic [cache_pkg::TAG_W-1:0]         tag,
    output logic [cache_pkg::OFFSET_W-1:0]      word,
    input  wire logic                           hit,
    input  wire logic                           line_valid,
    input  wire logic                           line_dirty,
    input  wire logic [cache_pkg::TAG_W-1:0]    victim_tag,
    input  wire logic [cache_pkg::DATA_W-1:0]   rd_word,
    output cache_pkg::line_wr_t                 line_wr,
    output mem_bus_pkg::ar_req_t                ar,
    input  wire logic                           arready,
    input  wire mem_bus_pkg::r_rsp_t            r,
    output logic                                rready,
    output mem_bus_pkg::ar_req_t                aw,
    input  wire logic                           awready,
    output mem_bus_pkg::w_req_t                 w,
    input  wire logic                           wready,
    input  wire logic                           bvalid,
    output logic                                bready
);
    import cache_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        QUERY,
        WB_AW,
        WB_W,
        WB_B,
        REFILL_AR,
        REFILL_R,
        COMMIT
    } state_t;

    state_t              state;
    cpu_req_t            req_q;
    addr_fields_t        fields;
    logic [OFFSET_W-1:0] wb_off;
    logic [OFFSET_W-1:0] wb_first;
    logic [OFFSET_W-1:0] rf_off;
    logic [STRB_W-1:0]   strb;

    assign fields = req_q.addr;

    // write-back wraps round so the requested word goes out last
    assign wb_first = fields.offset + 1'b1;

    always_comb begin
        case (req_q.size)
            SIZE_BYTE: strb = 4'b0001 << fields.byte_off;
            SIZE_HALF: strb = 4'b0011 << fields.byte_off;
            default:   strb = 4'b1111 << fields.byte_off;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu.req) state <= QUERY;
                end
                QUERY: begin
                    if (hit) begin
                        state <= req_q.wr ? COMMIT : IDLE;
                    end else if (line_valid && line_dirty) begin
                        state <= WB_AW;
                    end else begin
                        state <= REFILL_AR;
                    end
                end
                WB_AW: begin
                    if (awready) state <= WB_W;
                end
                WB_W: begin
                    if (wready && w.last) state <= WB_B;
                end
                WB_B: begin
                    if (bvalid) state <= REFILL_AR;
                end
                REFILL_AR: begin
                    if (arready) state <= REFILL_R;
                end
                REFILL_R: begin
                    if (r.valid && r.last) state <= QUERY;
                end
                COMMIT: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_q <= cpu;
        end
        if (state == WB_AW && awready) begin
            wb_off <= wb_first;
        end else if (w.valid && wready) begin
            wb_off <= wb_off + 1'b1;
        end
        // refill wraps from the requested word
        if (state == REFILL_AR && arready) begin
            rf_off <= fields.offset;
        end else if (state == REFILL_R && r.valid) begin
            rf_off <= rf_off + 1'b1;
        end
    end

    assign addr_ok = (state == IDLE) && cpu.req;
    assign data_ok = (state == QUERY) && hit;
    assign rdata   = rd_word;
    assign index   = fields.index;
    assign tag     = fields.tag;
    assign word    = (state == WB_W) ? wb_off : fields.offset;
    assign rready  = (state == REFILL_R);
    assign bready  = (state == WB_B);

    always_comb begin
        ar.addr  = {req_q.addr[ADDR_W-1:2], 2'b00};
        ar.len   = LINE_LEN;
        ar.size  = BEAT_SIZE_WORD;
        ar.burst = BURST_WRAP;
        ar.valid = (state == REFILL_AR);

        aw.addr  = {victim_tag, fields.index, wb_first, 2'b00};
        aw.len   = LINE_LEN;
        aw.size  = BEAT_SIZE_WORD;
        aw.burst = BURST_WRAP;
        aw.valid = (state == WB_AW);

        w.data  = rd_word;
        w.strb  = '1;
        w.last  = (wb_off == fields.offset);
        w.valid = (state == WB_W);
    end

    always_comb begin
        line_wr.en     = 1'b0;
        line_wr.index  = fields.index;
        line_wr.tag    = fields.tag;
        line_wr.offset = fields.offset;
        line_wr.data   = req_q.wdata;
        line_wr.strb   = strb;
        line_wr.dirty  = 1'b1;
        line_wr.valid  = 1'b1;
        case (state)
            COMMIT: line_wr.en = 1'b1;
            REFILL_R: begin
                line_wr.en     = r.valid;
                line_wr.offset = rf_off;
                line_wr.data   = r.data;
                line_wr.strb   = '1;
                line_wr.dirty  = 1'b0;
            end
            WB_W: begin
                // drop the victim once its last beat is taken
                line_wr.en    = wready && w.last;
                line_wr.strb  = '0;
                line_wr.dirty = 1'b0;
                line_wr.valid = 1'b0;
            end
            default: line_wr.en = 1'b0;
        endcase
    end

    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        ar.valid && !arready |=> ar.valid && $stable(ar.addr)
    );

    // victim stays untouched in storage while its beats go out
    a_w_in_writeback: assert property (
        @(posedge clk) disable iff (rst)
        w.valid |-> line_valid && line_dirty
    );

endmodule

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire cache_pkg::cpu_req_t      cpu,
    output logic [cache_pkg::DATA_W-1:0]  rdata,
    output logic                          addr_ok,
    output logic                          data_ok,
    output mem_bus_pkg::ar_req_t          ar,
    input  wire logic                     arready,
    output mem_bus_pkg::ar_req_t          aw,
    input  wire logic                     awready,
    input  wire mem_bus_pkg::r_rsp_t      r,
    output logic                          rready,
    output mem_bus_pkg::w_req_t           w,
    input  wire logic                     wready,
    input  wire logic                     bvalid,
    output logic                          bready
);
    import cache_pkg::*;

    line_wr_t            line_wr;
    line_rd_t            lines [NUM_LINES];
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    logic [OFFSET_W-1:0] word;
    logic                hit;
    logic                line_valid;
    logic                line_dirty;
    logic [TAG_W-1:0]    victim_tag;
    logic [DATA_W-1:0]   rd_word;

    cache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu        (cpu),
        .rdata      (rdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .index      (index),
        .tag        (tag),
        .word       (word),
        .hit        (hit),
        .line_valid (line_valid),
        .line_dirty (line_dirty),
        .victim_tag (victim_tag),
        .rd_word    (rd_word),
        .line_wr    (line_wr),
        .ar         (ar),
        .arready    (arready),
        .r          (r),
        .rready     (rready),
        .aw         (aw),
        .awready    (awready),
        .w          (w),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
        logic index_match;

        // only the addressed line takes the broadcast write
        assign index_match = line_wr.en && (line_wr.index == INDEX_W'(i));

        cache_line u_line (
            .clk         (clk),
            .rst         (rst),
            .index_match (index_match),
            .wr          (line_wr),
            .line        (lines[i])
        );
    end

    line_select u_select (
        .lines      (lines),
        .index      (index),
        .tag        (tag),
        .word       (word),
        .hit        (hit),
        .line_valid (line_valid),
        .line_dirty (line_dirty),
        .victim_tag (victim_tag),
        .rd_word    (rd_word)
    );

endmodule

`default_nettype wire

/* verif/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire mem_bus_pkg::ar_req_t ar,
    output logic                      arready,
    input  wire mem_bus_pkg::ar_req_t aw,
    output logic                      awready,
    output mem_bus_pkg::r_rsp_t       r,
    input  wire logic                 rready,
    input  wire mem_bus_pkg::w_req_t  w,
    output logic                      wready,
    output logic                      bvalid,
    input  wire logic                 bready
);
    localparam int MEM_WORDS = 16384;

    logic [31:0] mem [MEM_WORDS];
    logic [11:0] rd_line;
    logic [1:0]  rd_off;
    logic [1:0]  rd_cnt;
    logic        rd_busy;
    logic        r_valid;
    logic [11:0] wr_line;
    logic [1:0]  wr_off;
    logic        wr_busy;
    logic        b_pend;

    // every word differs and depends on all address bits
    function automatic logic [31:0] image_word(input logic [13:0] wi);
        logic [31:0] a;
        a = {16'd0, wi, 2'b00};
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995 ^ {a[15:0], a[31:16]};
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = image_word(14'(i));
        end
    end

    assign r = '{data: mem[{rd_line, rd_off}], last: (rd_cnt == 2'd3), valid: r_valid};

    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            r_valid <= 1'b0;
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            b_pend  <= 1'b0;
        end else begin
            arready <= !rd_busy && !(ar.valid && arready) && ($urandom_range(0, 2) == 0);
            if (ar.valid && arready) begin
                rd_busy <= 1'b1;
                rd_line <= ar.addr[15:4];
                rd_off  <= ar.addr[3:2];
                rd_cnt  <= 2'd0;
            end
            // wrap within the line by letting the offset roll over
            if (r_valid && rready) begin
                r_valid <= 1'b0;
                rd_off  <= rd_off + 2'd1;
                rd_cnt  <= rd_cnt + 2'd1;
                if (rd_cnt == 2'd3) rd_busy <= 1'b0;
            end else if (rd_busy && !r_valid) begin
                r_valid <= ($urandom_range(0, 1) == 0);
            end

            awready <= !wr_busy && !b_pend && !(aw.valid && awready) &&
                       ($urandom_range(0, 2) == 0);
            if (aw.valid && awready) begin
                wr_busy <= 1'b1;
                wr_line <= aw.addr[15:4];
                wr_off  <= aw.addr[3:2];
            end
            wready <= wr_busy && !(w.valid && wready && w.last) &&
                      ($urandom_range(0, 1) == 0);
            if (w.valid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (w.strb[b]) mem[{wr_line, wr_off}][8*b +: 8] <= w.data[8*b +: 8];
                end
                wr_off <= wr_off + 2'd1;
                if (w.last) begin
                    wr_busy <= 1'b0;
                    b_pend  <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
            end else if (b_pend && !bvalid) begin
                bvalid <= ($urandom_range(0, 1) == 0);
            end
        end
    end

endmodule

`default_nettype wire

/* verif/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;
    import cache_pkg::*;
    import mem_bus_pkg::*;

    localparam int NUM_REQ        = 400;
    localparam int CYCLES_PER_REQ = 80;
    localparam int CLK_PERIOD     = 10;
    localparam int SEED           = 77278;
    localparam int MEM_WORDS      = 16384;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu;
    logic [31:0] rdata;
    logic        addr_ok;
    logic        data_ok;
    ar_req_t     ar;
    ar_req_t     aw;
    r_rsp_t      r;
    w_req_t      w;
    logic        arready;
    logic        awready;
    logic        rready;
    logic        wready;
    logic        bvalid;
    logic        bready;

    logic [31:0]      shadow [MEM_WORDS];
    logic [TAG_W-1:0] model_tag [NUM_LINES];
    logic             model_valid [NUM_LINES];
    logic             model_dirty [NUM_LINES];
    cpu_req_t         cur;
    logic [31:0]      exp_rdata;
    logic             exp_hit;
    logic             acc_q;
    logic             pending;
    logic             seen_req;
    logic [2:0]       w_beats;
    logic [11:0]      wb_line;
    logic [3:0]       cur_ix;
    logic             wb_expected;
    logic [31:0]      aw_addr_exp;
    int               accepted;
    int               done;
    int               fail_count;

    dcache_top UUT (
        .clk(clk), .rst(rst), .cpu(cpu), .rdata(rdata), .addr_ok(addr_ok),
        .data_ok(data_ok), .ar(ar), .arready(arready), .aw(aw), .awready(awready),
        .r(r), .rready(rready), .w(w), .wready(wready), .bvalid(bvalid), .bready(bready)
    );

    axi_mem_model u_mem (
        .clk(clk), .rst(rst), .ar(ar), .arready(arready), .aw(aw), .awready(awready),
        .r(r), .rready(rready), .w(w), .wready(wready), .bvalid(bvalid), .bready(bready)
    );

    function automatic logic [31:0] image_word(input logic [13:0] wi);
        logic [31:0] a;
        a = {16'd0, wi, 2'b00};
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995 ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [3:0] strobe_for(input cpu_size_t size, input logic [1:0] off);
        case (size)
            SIZE_BYTE: return 4'b0001 << off;
            SIZE_HALF: return 4'b0011 << off;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic line_matches_shadow(input logic [11:0] line);
        for (int k = 0; k < 4; k++) begin
            if (u_mem.mem[{line, 2'(k)}] != shadow[{line, 2'(k)}]) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic report_fail(input string msg);
        fail_count++;
        $display("Fail %0t ns: %s", $time, msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    // request stays presented until its data_ok, so an early return to idle shows up
    task automatic issue_request(input logic wr, input cpu_size_t size, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        int acc0;
        int done0;
        acc0     = accepted;
        done0    = done;
        cpu      = '{req: 1'b1, wr: wr, size: size, addr: addr, wdata: wdata};
        seen_req = 1'b1;
        while (accepted == acc0) @(negedge clk);
        while (done == done0) @(negedge clk);
        cpu.req = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = image_word(14'(i));
        end
    end

    // reference cache state and expectations, updated on the CPU handshake
    always @(posedge clk) begin
        int ix;
        logic [13:0] wi;
        if (rst) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                model_valid[i] = 1'b0;
                model_dirty[i] = 1'b0;
                model_tag[i]   = '0;
            end
            pending  <= 1'b0;
            acc_q    <= 1'b0;
            accepted <= 0;
            done     <= 0;
            w_beats  <= 3'd0;
        end else begin
            acc_q <= addr_ok;
            if (addr_ok) begin
                wi = cpu.addr[15:2];
                ix = int'(cpu.addr[7:4]);
                cur       <= cpu;
                exp_rdata <= shadow[wi];
                exp_hit   <= model_valid[ix] && (model_tag[ix] == cpu.addr[31:8]);
                pending   <= 1'b1;
                accepted  <= accepted + 1;
                if (cpu.wr) begin
                    shadow[wi] = merge_word(shadow[wi], cpu.wdata,
                                            strobe_for(cpu.size, cpu.addr[1:0]));
                end
            end
            if (data_ok) begin
                ix = int'(cur.addr[7:4]);
                model_dirty[ix] = (exp_hit && model_dirty[ix]) || cur.wr;
                model_valid[ix] = 1'b1;
                model_tag[ix]   = cur.addr[31:8];
                pending <= 1'b0;
                done    <= done + 1;
            end
            if (aw.valid && awready) begin
                w_beats <= 3'd0;
                wb_line <= aw.addr[15:4];
            end else if (w.valid && wready) begin
                w_beats <= w_beats + 3'd1;
            end
        end
    end

    assign cur_ix = cur.addr[7:4];

    always_comb begin
        wb_expected = model_valid[cur_ix] && model_dirty[cur_ix] &&
                      (model_tag[cur_ix] != cur.addr[31:8]);
        aw_addr_exp = {model_tag[cur_ix], cur_ix, cur.addr[3:2] + 2'd1, 2'b00};
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_req |-> !data_ok && !ar.valid && !aw.valid && !w.valid && !rready && !bready)
        else report_fail("bus or data_ok active before the first request");
    a_read_data: assert property (@(posedge clk) disable iff (rst)
        data_ok && !cur.wr |-> rdata == exp_rdata)
        else report_fail("read data differs from shadow memory");
    a_ar_fields: assert property (@(posedge clk) disable iff (rst)
        ar.valid |-> !exp_hit && ar.addr == {cur.addr[31:2], 2'b00} && ar.len == 4'd3 &&
                     ar.size == 3'd2 && ar.burst == 2'd2)
        else report_fail("unexpected or malformed AR");
    a_aw_victim: assert property (@(posedge clk) disable iff (rst)
        aw.valid |-> wb_expected && aw.addr == aw_addr_exp && aw.len == 4'd3 &&
                     aw.size == 3'd2 && aw.burst == 2'd2)
        else report_fail("unexpected or malformed AW");
    a_w_strobe: assert property (@(posedge clk) disable iff (rst)
        w.valid |-> w.strb == 4'hf)
        else report_fail("write-back beat without full strobe");
    a_w_last: assert property (@(posedge clk) disable iff (rst)
        w.valid && wready |-> w.last == (w_beats == 3'd3))
        else report_fail("wlast not on the fourth beat");
    a_wb_copy: assert property (@(posedge clk) disable iff (rst)
        bvalid && bready |-> line_matches_shadow(wb_line))
        else report_fail("written-back line differs from shadow memory");
    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        acc_q && exp_hit |-> data_ok)
        else report_fail("hit did not answer one cycle after acceptance");
    a_done_pending: assert property (@(posedge clk) disable iff (rst)
        data_ok |-> pending)
        else report_fail("data_ok without an accepted request");
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        addr_ok |-> !pending)
        else report_fail("request accepted before previous data_ok");

    initial begin
        #(NUM_REQ * CYCLES_PER_REQ * CLK_PERIOD);
        $display("Timeout: the requests did not all complete in time");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        logic [31:0] base;
        logic [31:0] addr;
        cpu_size_t   size;
        logic        wr;
        void'($urandom(SEED));
        fail_count = 0;
        seen_req   = 1'b0;
        cpu        = '0;
        rst        = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < NUM_REQ; i++) begin
            // four windows share line indices 0 to 3 under different tags
            case ($urandom_range(0, 3))
                0:       base = 32'h0000_1000;
                1:       base = 32'h0000_2000;
                2:       base = 32'h0000_5000;
                default: base = 32'h0000_9000;
            endcase
            addr = base | 32'($urandom_range(0, 63));
            case ($urandom_range(0, 2))
                0: size = SIZE_BYTE;
                1: begin
                    size = SIZE_HALF;
                    addr[0] = 1'b0;
                end
                default: begin
                    size = SIZE_WORD;
                    addr[1:0] = 2'b00;
                end
            endcase
            wr = ($urandom_range(0, 1) == 1);
            issue_request(wr, size, addr, 32'($urandom()));
        end
        repeat (2) @(negedge clk);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/cache_pkg.sv
logic/mem_bus_pkg.sv
logic/cache_line.sv
logic/line_select.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
verif/axi_mem_model.sv
verif/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f sim.f --top-module dcache_tb -o dcache_sim; then
    echo "compile failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
